/* hw/pe_ctrl_pkg.sv */
`default_nettype none

package pe_ctrl_pkg;

	localparam int num_lanes = 16;
	localparam int dw_group = 5;
	localparam int dw_taps = 3;

	typedef logic [55:0] descriptor_t;
	typedef logic [4:0] dim_t;
	typedef logic [9:0] plane_t;
	typedef logic [15:0] psum_addr_t;

	// low bit of each descriptor field
	localparam int op_lsb = 0;
	localparam int ifmap_w_lsb = 3;
	localparam int ifmap_h_lsb = 8;
	localparam int ifmap_c_lsb = 13;
	localparam int filter_w_lsb = 18;
	localparam int filter_h_lsb = 22;
	localparam int filter_c_lsb = 26;
	localparam int filter_n_lsb = 31;
	localparam int ofmap_w_lsb = 36;
	localparam int ofmap_h_lsb = 41;
	localparam int ofmap_c_lsb = 46;
	localparam int ofmap_n_lsb = 51;

	// opcode field values, 3 bits wide
	localparam logic [2:0] op_dw = 3'd1;
	localparam logic [2:0] op_pw = 3'd2;

	typedef enum logic [1:0] {mode_none = 2'd0, mode_dw = 2'd1, mode_pw = 2'd2} mode_t;

	typedef enum logic [1:0] {layer_idle, layer_build, layer_run, layer_store} layer_state_t;

	typedef enum logic [1:0] {dw_idle, dw_load, dw_run, dw_check} dw_state_t;

	typedef enum logic [1:0] {pw_idle, pw_filter, pw_ifmap} pw_state_t;

endpackage

`default_nettype wire

/* hw/pe_ctrl_if.sv */
`timescale 1ns/100ps
`default_nettype none

// layer sizes and run control from the layer FSM
interface layer_cfg_if;
	import pe_ctrl_pkg::*;

	plane_t ifmap_plane;
	plane_t ofmap_plane;
	dim_t ofmap_c;
	dim_t filter_c;
	dim_t filter_n;
	logic dw_start;
	logic pw_start;
	logic dw_en;
	logic pw_en;

	modport ctrl (
		output ifmap_plane, ofmap_plane, ofmap_c, filter_c, filter_n,
		output dw_start, pw_start, dw_en, pw_en
	);
	modport seq (
		input ifmap_plane, ofmap_plane, ofmap_c, filter_c, filter_n,
		input dw_start, pw_start, dw_en, pw_en
	);
endinterface

// one sequencer's strobes and partial-sum lanes
interface seq_out_if;
	import pe_ctrl_pkg::*;

	logic ifmap_valid;
	logic weight_valid;
	logic [num_lanes-1:0] psum_valid;
	psum_addr_t [num_lanes-1:0] psum_addr;
	logic done;

	modport seq (output ifmap_valid, weight_valid, psum_valid, psum_addr, done);
	modport sel (input ifmap_valid, weight_valid, psum_valid, psum_addr);
endinterface

`default_nettype wire

/* hw/layer_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module layer_ctrl (
	input logic clk,
	input logic rst,
	input logic dla_start,
	input pe_ctrl_pkg::descriptor_t transfer_config,
	input logic all_done,
	input logic dw_done,
	input logic pw_done,
	layer_cfg_if.ctrl cfg,
	output pe_ctrl_pkg::mode_t mode,
	output logic store_is
);
	import pe_ctrl_pkg::*;

	layer_state_t state;
	layer_state_t state_nx;
	descriptor_t desc_q;
	logic start_q;
	logic running;
	dim_t ifmap_w;
	dim_t ifmap_h;
	dim_t ofmap_w;
	dim_t ofmap_h;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= layer_idle;
			desc_q <= '0;
			start_q <= 1'b0;
		end else begin
			state <= state_nx;
			// high in the first run cycle
			start_q <= (state == layer_build);
			if (state == layer_build)
				desc_q <= transfer_config;
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			layer_idle: if (dla_start) state_nx = layer_build;
			layer_build: state_nx = layer_run;
			// unknown opcodes never finish
			layer_run: if (dw_done || pw_done) state_nx = layer_store;
			layer_store: if (all_done) state_nx = layer_idle;
			default: state_nx = layer_idle;
		endcase
	end

	always_comb begin
		case (desc_q[op_lsb +: $bits(op_dw)])
			op_dw: mode = mode_dw;
			op_pw: mode = mode_pw;
			default: mode = mode_none;
		endcase
	end

	assign ifmap_w = desc_q[ifmap_w_lsb +: $bits(dim_t)];
	assign ifmap_h = desc_q[ifmap_h_lsb +: $bits(dim_t)];
	assign ofmap_w = desc_q[ofmap_w_lsb +: $bits(dim_t)];
	assign ofmap_h = desc_q[ofmap_h_lsb +: $bits(dim_t)];

	assign cfg.ofmap_c = desc_q[ofmap_c_lsb +: $bits(dim_t)];
	assign cfg.filter_c = desc_q[filter_c_lsb +: $bits(dim_t)];
	assign cfg.filter_n = desc_q[filter_n_lsb +: $bits(dim_t)];
	assign cfg.ifmap_plane = plane_t'(ifmap_w) * plane_t'(ifmap_h);
	assign cfg.ofmap_plane = plane_t'(ofmap_w) * plane_t'(ofmap_h);

	assign running = (state == layer_run);
	assign cfg.dw_en = running && (mode == mode_dw);
	assign cfg.pw_en = running && (mode == mode_pw);
	assign cfg.dw_start = cfg.dw_en && start_q;
	assign cfg.pw_start = cfg.pw_en && start_q;

	assign store_is = (state == layer_store);

endmodule

`default_nettype wire

/* hw/dw_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module dw_seq (
	input logic clk,
	input logic rst,
	input logic ifmap_ready,
	input logic ifmap_3_ready,
	input logic weight_ready,
	layer_cfg_if.seq cfg,
	seq_out_if.seq out
);
	import pe_ctrl_pkg::*;

	dw_state_t state;
	dw_state_t state_nx;
	logic [1:0] tap;
	plane_t pixel;
	dim_t base;
	dim_t remain;
	logic hsk;
	logic pixel_end;
	logic group_end;
	logic last_group;
	logic [dw_group-1:0] lane_valid_q;
	psum_addr_t [dw_group-1:0] lane_addr_q;

	assign hsk = (state == dw_run) && ifmap_ready;
	assign pixel_end = hsk && (tap == 2'(dw_taps - 1));
	assign group_end = pixel_end && (pixel == cfg.ofmap_plane - plane_t'(1));
	// six bits so base + group cannot wrap
	assign last_group = ({1'b0, base} + 6'(dw_group)) >= {1'b0, cfg.ofmap_c};
	assign remain = cfg.ofmap_c - base;

	always_comb begin
		state_nx = state;
		case (state)
			dw_idle: if (cfg.dw_start) state_nx = dw_load;
			dw_load: if (ifmap_3_ready && weight_ready) state_nx = dw_run;
			dw_run: begin
				if (group_end && last_group)
					state_nx = dw_idle;
				else if (pixel_end)
					state_nx = dw_check;
			end
			dw_check: state_nx = dw_load;
			default: state_nx = dw_idle;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= dw_idle;
			tap <= '0;
			pixel <= '0;
			base <= '0;
		end else if (!cfg.dw_en) begin
			state <= dw_idle;
			tap <= '0;
			pixel <= '0;
			base <= '0;
		end else begin
			state <= state_nx;
			if (pixel_end)
				tap <= '0;
			else if (hsk)
				tap <= tap + 2'd1;
			if (group_end) begin
				pixel <= '0;
				base <= base + dim_t'(dw_group);
			end else if (pixel_end) begin
				pixel <= pixel + plane_t'(1);
			end
		end
	end

	// lanes registered one cycle after the pixel's last tap
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_valid_q <= '0;
			lane_addr_q <= '0;
		end else begin
			for (int i = 0; i < dw_group; i++) begin
				lane_valid_q[i] <= pixel_end && (dim_t'(i) < remain);
				if (pixel_end)
					lane_addr_q[i] <= (psum_addr_t'(base) + psum_addr_t'(i))
						* psum_addr_t'(cfg.ofmap_plane) + psum_addr_t'(pixel);
			end
		end
	end

	always_comb begin
		out.psum_valid = '0;
		out.psum_addr = '0;
		out.psum_valid[dw_group-1:0] = lane_valid_q;
		out.psum_addr[dw_group-1:0] = lane_addr_q;
	end

	assign out.ifmap_valid = (state == dw_run);
	assign out.weight_valid = group_end;
	assign out.done = group_end && last_group;

endmodule

`default_nettype wire

/* hw/pw_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module pw_seq (
	input logic clk,
	input logic rst,
	input logic ifmap_ready,
	input logic weight_ready,
	layer_cfg_if.seq cfg,
	seq_out_if.seq out
);
	import pe_ctrl_pkg::*;

	localparam dim_t grp = dim_t'(num_lanes);

	pw_state_t state;
	dim_t chan_left;
	dim_t filt_left;
	dim_t next_filt;
	dim_t drain_left;
	plane_t pix_left;
	logic ifmap_valid;
	logic hsk;
	logic pass_end;
	logic more_chan;
	logic more_filt;
	logic done_q;
	logic [num_lanes-1:0] lane_valid_q;
	psum_addr_t [num_lanes-1:0] lane_addr_q;

	function automatic dim_t group_size(dim_t left);
		return (left < grp) ? left : grp;
	endfunction

	assign ifmap_valid = (state == pw_ifmap) && (pix_left != '0);
	assign hsk = ifmap_valid && ifmap_ready;
	// last drain cycle of the pass
	assign pass_end = (state == pw_ifmap) && (pix_left == '0) && (drain_left == dim_t'(1));
	assign more_chan = chan_left > grp;
	assign more_filt = filt_left > grp;
	assign next_filt = filt_left - grp;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= pw_idle;
			chan_left <= '0;
			filt_left <= '0;
			drain_left <= '0;
			pix_left <= '0;
			done_q <= 1'b0;
		end else if (!cfg.pw_en) begin
			state <= pw_idle;
			chan_left <= '0;
			filt_left <= '0;
			drain_left <= '0;
			pix_left <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				pw_idle: begin
					if (cfg.pw_start) begin
						state <= pw_filter;
						chan_left <= cfg.filter_c;
						filt_left <= cfg.filter_n;
						pix_left <= cfg.ifmap_plane;
						drain_left <= group_size(cfg.filter_n);
					end
				end
				pw_filter: if (weight_ready) state <= pw_ifmap;
				pw_ifmap: begin
					if (pix_left != '0) begin
						if (hsk)
							pix_left <= pix_left - plane_t'(1);
					end else if (!pass_end) begin
						drain_left <= drain_left - dim_t'(1);
					end else begin
						pix_left <= cfg.ifmap_plane;
						// channel groups first, then filter groups
						if (more_chan) begin
							state <= pw_filter;
							chan_left <= chan_left - grp;
							drain_left <= group_size(filt_left);
						end else if (more_filt) begin
							state <= pw_filter;
							chan_left <= cfg.filter_c;
							filt_left <= next_filt;
							drain_left <= group_size(next_filt);
						end else begin
							state <= pw_idle;
							done_q <= 1'b1;
						end
					end
				end
				default: state <= pw_idle;
			endcase
		end
	end

	// lane 0 follows the handshake, lane i trails lane i-1 by a cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lane_valid_q <= '0;
			lane_addr_q <= '0;
		end else if (!cfg.pw_en) begin
			lane_valid_q <= '0;
			lane_addr_q <= '0;
		end else begin
			lane_valid_q <= {lane_valid_q[num_lanes-2:0], hsk};
			for (int i = 0; i < num_lanes; i++) begin
				if (cfg.pw_start)
					lane_addr_q[i] <= psum_addr_t'(i) * psum_addr_t'(cfg.ifmap_plane);
				else if (lane_valid_q[i])
					lane_addr_q[i] <= lane_addr_q[i] + psum_addr_t'(1);
			end
		end
	end

	assign out.ifmap_valid = ifmap_valid;
	assign out.weight_valid = pass_end;
	assign out.psum_valid = lane_valid_q;
	assign out.psum_addr = lane_addr_q;
	assign out.done = done_q;

endmodule

`default_nettype wire

/* hw/lane_select.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_select (
	input pe_ctrl_pkg::mode_t mode,
	seq_out_if.sel dw,
	seq_out_if.sel pw,
	output logic ifmap_valid,
	output logic weight_valid,
	output logic [pe_ctrl_pkg::num_lanes-1:0] psum_valid,
	output pe_ctrl_pkg::psum_addr_t [pe_ctrl_pkg::num_lanes-1:0] psum_addr
);
	import pe_ctrl_pkg::*;

	always_comb begin
		case (mode)
			mode_dw: begin
				ifmap_valid = dw.ifmap_valid;
				weight_valid = dw.weight_valid;
				psum_valid = dw.psum_valid;
				psum_addr = dw.psum_addr;
			end
			mode_pw: begin
				ifmap_valid = pw.ifmap_valid;
				weight_valid = pw.weight_valid;
				psum_valid = pw.psum_valid;
				psum_addr = pw.psum_addr;
			end
			default: begin
				ifmap_valid = 1'b0;
				weight_valid = 1'b0;
				psum_valid = '0;
				psum_addr = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/pe_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module pe_controller (
	input logic clk,
	input logic rst,
	input logic dla_start,
	input pe_ctrl_pkg::descriptor_t transfer_config,
	input logic ifmap_ready,
	input logic ifmap_3_ready,
	input logic weight_ready,
	input logic all_done,
	output logic ifmap_valid,
	output logic weight_valid,
	output logic [pe_ctrl_pkg::num_lanes-1:0] psum_valid,
	output pe_ctrl_pkg::psum_addr_t [pe_ctrl_pkg::num_lanes-1:0] psum_addr,
	output pe_ctrl_pkg::mode_t mode,
	output logic store_is
);

	layer_cfg_if i_cfg ();
	seq_out_if i_dw_out ();
	seq_out_if i_pw_out ();

	layer_ctrl i_layer_ctrl (
		.clk(clk),
		.rst(rst),
		.dla_start(dla_start),
		.transfer_config(transfer_config),
		.all_done(all_done),
		.dw_done(i_dw_out.done),
		.pw_done(i_pw_out.done),
		.cfg(i_cfg.ctrl),
		.mode(mode),
		.store_is(store_is)
	);

	dw_seq i_dw_seq (
		.clk(clk),
		.rst(rst),
		.ifmap_ready(ifmap_ready),
		.ifmap_3_ready(ifmap_3_ready),
		.weight_ready(weight_ready),
		.cfg(i_cfg.seq),
		.out(i_dw_out.seq)
	);

	pw_seq i_pw_seq (
		.clk(clk),
		.rst(rst),
		.ifmap_ready(ifmap_ready),
		.weight_ready(weight_ready),
		.cfg(i_cfg.seq),
		.out(i_pw_out.seq)
	);

	lane_select i_lane_select (
		.mode(mode),
		.dw(i_dw_out.sel),
		.pw(i_pw_out.sel),
		.ifmap_valid(ifmap_valid),
		.weight_valid(weight_valid),
		.psum_valid(psum_valid),
		.psum_addr(psum_addr)
	);

endmodule

`default_nettype wire

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic check_mode(input string name, input mode_t exp, input mode_t act);
	if (act !== exp) begin
		$display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
		$display("Simulation FAILED");
		$fatal(1, "mode mismatch");
	end
endtask

task automatic check_count(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		$display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "count mismatch");
	end
endtask

task automatic check_addr(input string name, input psum_addr_t exp, input psum_addr_t act);
	if (act !== exp) begin
		$display("[FAIL] %s: expected 0x%04h, actual 0x%04h", name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "address mismatch");
	end
endtask

task automatic check_flag(input string name, input bit exp, input bit act);
	if (act !== exp) begin
		$display("[FAIL] %s: expected %0b, actual %0b", name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "flag mismatch");
	end
endtask

`endif

/* tb/tb_pe_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pe_controller;
	import pe_ctrl_pkg::*;

	`include "tb_checks.svh"

	localparam int max_layers = 16;

	logic clk;
	logic rst;
	logic dla_start;
	descriptor_t transfer_config;
	logic ifmap_ready;
	logic ifmap_3_ready;
	logic weight_ready;
	logic all_done;
	logic ifmap_valid;
	logic weight_valid;
	logic [num_lanes-1:0] psum_valid;
	psum_addr_t [num_lanes-1:0] psum_addr;
	mode_t mode;
	logic store_is;

	// four words per layer for the descriptor and the three expected totals
	logic [63:0] layer_mem [0:4*max_layers-1];
	integer seed;
	int num_layers;
	int timeout_cycles;
	int cur_oplane;
	int cur_iplane;
	int cur_ofmap_c;
	mode_t exp_mode;
	bit check_on;

	// reference model state kept by the monitor
	int hsk_cnt;
	int wt_cnt;
	int l0_cnt;
	int store_rises;
	bit store_q;
	int dw_tap;
	int dw_pix;
	int dw_base;
	bit pend;
	int pend_base;
	int pend_pix;
	bit hsk_q;
	logic [num_lanes-1:0] psum_q;
	int lane_cnt [num_lanes];

	pe_controller i_pe_controller (
		.clk(clk),
		.rst(rst),
		.dla_start(dla_start),
		.transfer_config(transfer_config),
		.ifmap_ready(ifmap_ready),
		.ifmap_3_ready(ifmap_3_ready),
		.weight_ready(weight_ready),
		.all_done(all_done),
		.ifmap_valid(ifmap_valid),
		.weight_valid(weight_valid),
		.psum_valid(psum_valid),
		.psum_addr(psum_addr),
		.mode(mode),
		.store_is(store_is)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// each ready high about 3 cycles in 4
	initial begin
		seed = 97019;
		ifmap_ready = 1'b0;
		ifmap_3_ready = 1'b0;
		weight_ready = 1'b0;
		forever begin
			@(posedge clk);
			ifmap_ready <= ($random(seed) & 3) != 0;
			ifmap_3_ready <= ($random(seed) & 3) != 0;
			weight_ready <= ($random(seed) & 3) != 0;
		end
	end

	always @(negedge clk) begin : monitor
		int lanes_exp;
		bit hsk;
		bit was_store;
		hsk = ifmap_valid && ifmap_ready;
		if (dla_start) begin
			hsk_cnt = 0;
			wt_cnt = 0;
			l0_cnt = 0;
			store_rises = 0;
			store_q = 1'b0;
			dw_tap = 0;
			dw_pix = 0;
			dw_base = 0;
			pend = 1'b0;
			hsk_q = 1'b0;
			psum_q = '0;
			for (int i = 0; i < num_lanes; i++)
				lane_cnt[i] = 0;
		end else if (check_on) begin
			check_mode("layer mode", exp_mode, mode);
			was_store = store_q;
			if (store_is && !store_q)
				store_rises++;
			store_q = store_is;
			if (weight_valid)
				wt_cnt++;
			if (psum_valid[0])
				l0_cnt++;
			if (hsk)
				hsk_cnt++;
			if (exp_mode == mode_dw) begin
				lanes_exp = 0;
				if (pend) begin
					lanes_exp = cur_ofmap_c - pend_base;
					if (lanes_exp > dw_group)
						lanes_exp = dw_group;
				end
				check_count("dw valid lanes", lanes_exp, $countones(psum_valid));
				for (int i = 0; i < lanes_exp; i++) begin
					check_flag("dw lane valid", 1'b1, psum_valid[i]);
					check_addr("dw lane addr",
						psum_addr_t'((pend_base + i) * cur_oplane + pend_pix), psum_addr[i]);
				end
				pend = 1'b0;
				// third tap closes a pixel
				if (hsk) begin
					if (dw_tap == dw_taps - 1) begin
						pend = 1'b1;
						pend_base = dw_base;
						pend_pix = dw_pix;
						dw_tap = 0;
						if (dw_pix == cur_oplane - 1) begin
							dw_pix = 0;
							dw_base = dw_base + dw_group;
						end else begin
							dw_pix++;
						end
					end else begin
						dw_tap++;
					end
				end
			end else begin
				check_flag("pw lane 0 follows handshake", hsk_q, psum_valid[0]);
				// lanes clear one cycle after the layer leaves run
				for (int i = 1; i < num_lanes; i++)
					check_flag($sformatf("pw lane %0d follows lane %0d", i, i - 1),
						psum_q[i-1] && !was_store, psum_valid[i]);
				for (int i = 0; i < num_lanes; i++) begin
					if (psum_valid[i]) begin
						check_addr("pw lane addr",
							psum_addr_t'(i * cur_iplane + lane_cnt[i]), psum_addr[i]);
						lane_cnt[i]++;
					end
				end
				hsk_q = hsk;
				psum_q = psum_valid;
			end
		end
	end

	initial begin : watchdog
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: layers did not finish within %0d cycles", timeout_cycles);
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic run_layer(input int idx);
		descriptor_t desc;
		desc = layer_mem[4*idx][55:0];
		exp_mode = (desc[op_lsb +: 3] == op_dw) ? mode_dw : mode_pw;
		cur_oplane = int'(desc[ofmap_w_lsb +: 5]) * int'(desc[ofmap_h_lsb +: 5]);
		cur_iplane = int'(desc[ifmap_w_lsb +: 5]) * int'(desc[ifmap_h_lsb +: 5]);
		cur_ofmap_c = int'(desc[ofmap_c_lsb +: 5]);
		@(posedge clk);
		transfer_config <= desc;
		dla_start <= 1'b1;
		@(posedge clk);
		dla_start <= 1'b0;
		// descriptor registered after this edge
		@(posedge clk);
		check_on = 1'b1;
		do @(negedge clk); while (!store_is);
		@(posedge clk);
		all_done <= 1'b1;
		@(posedge clk);
		all_done <= 1'b0;
		@(negedge clk);
		check_flag($sformatf("layer %0d store_is after all_done", idx), 1'b0, store_is);
		@(posedge clk);
		check_count($sformatf("layer %0d ifmap handshakes", idx),
			32'(layer_mem[4*idx+1]), hsk_cnt);
		check_count($sformatf("layer %0d weight pulses", idx),
			32'(layer_mem[4*idx+2]), wt_cnt);
		check_count($sformatf("layer %0d lane 0 pulses", idx),
			32'(layer_mem[4*idx+3]), l0_cnt);
		check_count($sformatf("layer %0d store_is rises", idx), 1, store_rises);
		check_on = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		dla_start = 1'b0;
		transfer_config = '0;
		all_done = 1'b0;
		check_on = 1'b0;
		timeout_cycles = 0;
		$readmemh("tb/layer_input.txt", layer_mem);
		// all-zero descriptor ends the list
		num_layers = 0;
		while (num_layers < max_layers && layer_mem[4*num_layers] != 64'h0)
			num_layers++;
		timeout_cycles = 200;
		for (int n = 0; n < num_layers; n++)
			timeout_cycles += 40 * int'(layer_mem[4*n+1]) + 100;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("reset ifmap_valid", 1'b0, ifmap_valid);
		check_flag("reset weight_valid", 1'b0, weight_valid);
		check_count("reset psum_valid", 0, $countones(psum_valid));
		check_flag("reset store_is", 1'b0, store_is);
		check_mode("reset mode", mode_none, mode);
		for (int n = 0; n < num_layers; n++)
			run_layer(n);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/layer_input.txt */
// descriptor, ifmap handshakes, weight_valid pulses, lane 0 psum pulses (all hex)
// opcode 1 is depthwise, opcode 2 is pointwise
03064000000001 6C 3 24
0000095000042A 50 4 50
01442000000001 C 1 4
0000084000031A 9 1 9
00425000000001 F 1 5
00000F8400010A 2 2 2
07C63000000001 BD 7 3F
000002FC000232 18 2 18
01821000000001 6 2 2
// end of list
00000000000000 0 0 0

/* tb.f */
hw/pe_ctrl_pkg.sv
hw/pe_ctrl_if.sv
hw/layer_ctrl.sv
hw/dw_seq.sv
hw/pw_seq.sv
hw/lane_select.sv
hw/pe_controller.sv
+incdir+include
tb/tb_pe_controller.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pe_controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f tb.f --top-module tb_pe_controller \
	--Mdir obj_dir -o sim_pe_controller
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim_pe_controller
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
fi
exit $sim_status
